// ==== all.f ====
debugPkg.sv
setupDecoder.sv
requestFsm.sv
transferCounter.sv
configAddress.sv
responseRegs.sv
debugControl.sv
tbChecker.sv
tbDebugControl.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tbDebugControl -f all.f -o simDebugControl
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/simDebugControl)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

// ==== tbDebugControl.sv ====
module tbDebugControl;
	timeunit 1ns;
	timeprecision 1ps;
	import debugPkg::*;

	localparam int numRequests = 60;
	localparam int maxBurst = 8;   // wLength 0 to 7
	localparam int cycleLimit = 20 + numRequests * (8 + 2 * maxBurst);

	logic clk;
	logic rst;
	logic enable;
	setupT setupWord;
	dataT parameterBlock32;
	addrT parameterBlock64;
	dataT operatingModeIn;
	logic busy;
	logic targetGlobal;
	logic targetLocal;
	logic targetSpecific;
	byteT debugUnitId;
	byteT interfaceId;
	logic writeStrobe;
	addrT writeAddress;
	dataT writeData;
	dataT modeOut;
	logic readValid;
	dataT readData32;
	addrT readData64;
	logic reqStart;
	logic reqDone;
	int passCount;
	int failCount;
	int seed;
	int cycleCount;

	debugControl #(.countWidth(16)) DUT (.*);

	tbChecker scoreboard (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reqPick 0..6 are the kept requests in checker order, 7 is unknown
	function automatic setupT makeSetup(input int reqPick, input int targetPick, input int len,
		input logic [31:0] noise);
		byteT reqType;
		byteT code;
		byteT classCode;
		byteT unit;
		reqType = (reqPick >= 3) ? ReqTypeGet : ReqTypeSet;
		case (reqPick)
			0: code = ReqSetConfigData;
			1: code = ReqSetConfigAddress;
			2: code = ReqSetOperatingMode;
			3: code = ReqGetConfigAddress;
			4: code = ReqGetOperatingMode;
			5: code = ReqGetInfo;
			6: code = ReqGetError;
			default:
			begin
				reqType = noise[0] ? 8'h40 : ReqTypeSet;   // vendor type, or a get code on set
				code = ReqGetInfo;
			end
		endcase
		classCode = (targetPick == 1) ? ClassLocal : ClassGlobal;
		unit = 8'h00;
		if (targetPick == 2)
			unit = {noise[14:8], 1'b1};   // any nonzero unit
		else if (targetPick == 3)
		begin
			classCode = {1'b1, noise[22:16]};   // vendor wValue code
			unit = noise[31:24];
		end
		return {reqType, code, noise[7:0], classCode, unit, noise[31:24], len[15:0]};
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		parameterBlock32 <= $random(seed);   // fresh word every cycle
	endtask

	// edges is the number of enabled clock edges the request takes
	task automatic runRequest(input setupT word, input int edges, input logic stall);
		int done;
		int drops;
		int quiet;
		done = 0;
		drops = 0;
		quiet = 0;
		nextCycle();
		setupWord <= word;
		parameterBlock64 <= {$random(seed), $random(seed)};
		operatingModeIn <= $random(seed);
		enable <= 1'b1;
		reqStart <= 1'b1;
		while (done < edges)
		begin
			nextCycle();
			reqStart <= 1'b0;
			if (enable)
				done++;
			if (done >= edges)
				enable <= 1'b0;   // back in Idle, hold it there
			else if (stall && drops < 4 && ($random(seed) & 3) == 0)
			begin
				enable <= 1'b0;
				drops++;
			end
			else
				enable <= 1'b1;
		end
		while (quiet < 2)
		begin
			nextCycle();
			quiet = busy ? 0 : quiet + 1;
		end
		reqDone <= 1'b1;
		nextCycle();
		reqDone <= 1'b0;
	endtask

	initial
	begin
		int i;
		int reqPick;
		int targetPick;
		int len;
		int edges;
		int errorReads;
		logic bad;
		setupT word;
		seed = 15;
		rst = 1'b1;
		enable = 1'b0;
		setupWord = '0;
		parameterBlock32 = '0;
		parameterBlock64 = '0;
		operatingModeIn = '0;
		reqStart = 1'b0;
		reqDone = 1'b0;
		errorReads = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (2) nextCycle();

		for (i = 0; i < numRequests; i++)
		begin
			reqPick = $unsigned($random(seed)) % 8;
			targetPick = $unsigned($random(seed)) % 4;
			len = $unsigned($random(seed)) % maxBurst;
			if (i == 0)
			begin
				reqPick = 3;   // address straight out of reset
				targetPick = 0;
			end
			else if (errorReads > 0)
			begin
				reqPick = 6;   // read the code, then read it cleared
				targetPick = targetPick % 3;
				errorReads--;
			end
			bad = (reqPick == 7) || (targetPick == 3);
			if (bad)
				errorReads = 2;
			word = makeSetup(reqPick, targetPick, len, $random(seed));
			edges = bad ? 2 : ((reqPick == 0) ? len + 3 : 3);
			runRequest(word, edges, ($random(seed) & 3) == 0);
		end

		nextCycle();
		$display("tests checked: %0d ok, %0d with errors", passCount, failCount);
		if (failCount == 0 && passCount == numRequests + 1)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("run timed out after %0d cycles", cycleCount);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== tbChecker.sv ====
module tbChecker (
	input logic clk,
	input logic rst,
	input logic reqStart,
	input logic reqDone,
	input logic enable,
	input debugPkg::setupT setupWord,
	input debugPkg::dataT parameterBlock32,
	input debugPkg::addrT parameterBlock64,
	input debugPkg::dataT operatingModeIn,
	input logic busy,
	input logic targetGlobal,
	input logic targetLocal,
	input logic targetSpecific,
	input debugPkg::byteT debugUnitId,
	input debugPkg::byteT interfaceId,
	input logic writeStrobe,
	input debugPkg::addrT writeAddress,
	input debugPkg::dataT writeData,
	input debugPkg::dataT modeOut,
	input logic readValid,
	input debugPkg::dataT readData32,
	input debugPkg::addrT readData64,
	output int passCount,
	output int failCount
);
	timeunit 1ns;
	timeprecision 1ps;
	import debugPkg::*;

	// one bit per kept function
	localparam dataT expectedInfo = (32'd1 << 1) | (32'd1 << 3) | (32'd1 << 4)
		| (32'd1 << 7) | (32'd1 << 8);

	int reqIndex;
	int kind;      // 0 SetData .. 6 GetError, 7 unknown request
	int target;    // 0 global, 1 local, 2 specific, 3 vendor
	int wLen;
	int enabledIdle;
	int enabledBusy;
	int firstBusy;
	int strobes;
	int reads;
	int errs;
	logic active;
	logic resetPending;
	string label;
	setupT word;
	addrT modelAddr;
	dataT modelMode;
	dataT sampledMode;   // parameterBlock32 on the last enabled busy cycle
	errT modelErr;
	dataT burstData[$];

	function automatic int decodeRequest(input byteT reqType, input byteT code);
		if (reqType == ReqTypeSet && code == ReqSetConfigData)
			return 0;
		if (reqType == ReqTypeSet && code == ReqSetConfigAddress)
			return 1;
		if (reqType == ReqTypeSet && code == ReqSetOperatingMode)
			return 2;
		if (reqType == ReqTypeGet && code == ReqGetConfigAddress)
			return 3;
		if (reqType == ReqTypeGet && code == ReqGetOperatingMode)
			return 4;
		if (reqType == ReqTypeGet && code == ReqGetInfo)
			return 5;
		if (reqType == ReqTypeGet && code == ReqGetError)
			return 6;
		return 7;
	endfunction

	// wValue low byte plus unit id from the wIndex high byte
	function automatic int classifyTarget(input byteT classCode, input byteT unit);
		if (unit == 8'h00 && classCode == ClassGlobal)
			return 0;
		if (unit == 8'h00 && classCode == ClassLocal)
			return 1;
		if (unit != 8'h00 && classCode == ClassSpecific)
			return 2;
		return 3;
	endfunction

	function automatic string kindName(input int k);
		case (k)
			0: return "SetData";
			1: return "SetAddress";
			2: return "SetMode";
			3: return "GetAddress";
			4: return "GetMode";
			5: return "GetInfo";
			6: return "GetError";
			default: return "unknown";
		endcase
	endfunction

	function automatic string targetName(input int t);
		case (t)
			0: return "global";
			1: return "local";
			2: return "specific";
			default: return "vendor";
		endcase
	endfunction

	task automatic reportMismatch(input string msg);
		$display("mismatch at %0t: %s: %s", $time, label, msg);
		errs++;
	endtask

	task automatic reportProblem(input string msg);
		$display("error at %0t: %s: %s", $time, label, msg);
		errs++;
	endtask

	task automatic closeTest();
		if (errs == 0)
		begin
			passCount++;
			$display("%s: ok", label);
		end
		else
		begin
			failCount++;
			$display("%s: %0d error(s)", label, errs);
		end
	endtask

	task automatic checkResetState();
		resetPending = 1'b0;
		errs = 0;
		label = "reset state";
		if (busy || writeStrobe || readValid)
			reportMismatch("busy or a strobe is high after reset");
		if (targetGlobal || targetLocal || targetSpecific)
			reportMismatch("a target flag is high after reset");
		if (modeOut !== '0)
			reportMismatch($sformatf("modeOut %h, expected 0", modeOut));
		closeTest();
	endtask

	task automatic beginRequest();
		word = setupWord;
		kind = decodeRequest(word[63:56], word[55:48]);
		target = classifyTarget(word[39:32], word[31:24]);
		wLen = int'(word[15:0]);
		reqIndex++;
		label = $sformatf("request %0d %s to %s", reqIndex, kindName(kind), targetName(target));
		enabledIdle = 0;
		enabledBusy = 0;
		firstBusy = -1;
		strobes = 0;
		reads = 0;
		errs = 0;
		burstData.delete();
		active = 1'b1;
	endtask

	task automatic checkWrite();
		dataT expected;
		if (burstData.size() == 0)
			reportProblem("write strobe without an enabled burst cycle before it");
		else
		begin
			expected = burstData.pop_front();
			if (writeAddress !== modelAddr + 64'(strobes))
				reportMismatch($sformatf("writeAddress %h, expected %h", writeAddress,
					modelAddr + 64'(strobes)));
			if (writeData !== expected)
				reportMismatch($sformatf("writeData %h, expected %h", writeData, expected));
		end
		strobes++;
	endtask

	task automatic checkRead();
		reads++;
		case (kind)
			3: if (readData64 !== modelAddr)
				reportMismatch($sformatf("readData64 %h, expected %h", readData64, modelAddr));
			4: if (readData32 !== operatingModeIn)
				reportMismatch($sformatf("readData32 %h, expected %h", readData32,
					operatingModeIn));
			5: if (readData32 !== expectedInfo)
				reportMismatch($sformatf("readData32 %h, expected %h", readData32,
					expectedInfo));
			6: if (readData32 !== dataT'(modelErr))
				reportMismatch($sformatf("error code %h, expected %h", readData32, modelErr));
			default: reportProblem("readValid pulsed for a request that returns no data");
		endcase
	endtask

	task automatic watchCycle();
		if (!active)
		begin
			if (writeStrobe || readValid)
			begin
				$display("error at %0t: a strobe fired with no request in flight", $time);
				failCount++;
			end
			return;
		end
		if (busy && firstBusy < 0)
			firstBusy = enabledIdle;
		if (enable && busy)
		begin
			enabledBusy++;
			sampledMode = parameterBlock32;
			if (kind == 0)
				burstData.push_back(parameterBlock32);   // word for this burst cycle
		end
		else if (enable)
			enabledIdle++;
		if (writeStrobe)
			checkWrite();
		if (readValid)
			checkRead();
	endtask

	task automatic finishRequest();
		logic bad;
		int expectBusy;
		bad = (kind == 7) || (target == 3);
		expectBusy = bad ? 0 : ((kind == 0) ? wLen + 1 : 1);
		if (enabledBusy != expectBusy)
			reportMismatch($sformatf("busy for %0d enabled cycles, expected %0d",
				enabledBusy, expectBusy));
		if (!bad && firstBusy != 2)
			reportMismatch($sformatf("busy rose after %0d enabled cycles, expected 2", firstBusy));
		if (strobes != ((!bad && kind == 0) ? wLen + 1 : 0))
			reportMismatch($sformatf("%0d write strobes", strobes));
		if (reads != ((!bad && kind >= 3 && kind <= 6) ? 1 : 0))
			reportMismatch($sformatf("%0d readValid pulses", reads));
		if ({targetGlobal, targetLocal, targetSpecific} !==
			{target == 0, target == 1, target == 2})
			reportMismatch("target flags do not match wValue and wIndex");
		if (debugUnitId !== word[31:24] || interfaceId !== word[23:16])
			reportMismatch($sformatf("ids %h/%h, expected %h/%h", debugUnitId, interfaceId,
				word[31:24], word[23:16]));

		// model update
		if (bad)
			modelErr = (kind == 7) ? ErrInvalidRequest : ErrInvalidControl;
		else
		begin
			case (kind)
				1: modelAddr = parameterBlock64;
				2: modelMode = sampledMode;
				6: modelErr = ErrNone;   // cleared once read
				default: ;
			endcase
		end
		if (modeOut !== modelMode)
			reportMismatch($sformatf("modeOut %h, expected %h", modeOut, modelMode));
		active = 1'b0;
		closeTest();
	endtask

	always @(negedge clk)
	begin
		if (rst)
		begin
			resetPending = 1'b1;
			active = 1'b0;
			passCount = 0;
			failCount = 0;
			reqIndex = 0;
			modelAddr = '0;
			modelMode = '0;
			modelErr = ErrNone;
		end
		else
		begin
			if (resetPending)
				checkResetState();
			if (reqStart)
				beginRequest();
			watchCycle();
			if (reqDone)
				finishRequest();
		end
	end

endmodule

// ==== debugControl.sv ====
module debugControl #(
	parameter int countWidth = 16
) (
	input logic clk,
	input logic rst,
	input logic enable,
	input debugPkg::setupT setupWord,
	input debugPkg::dataT parameterBlock32,
	input debugPkg::addrT parameterBlock64,
	input debugPkg::dataT operatingModeIn,
	output logic busy,
	output logic targetGlobal,
	output logic targetLocal,
	output logic targetSpecific,
	output debugPkg::byteT debugUnitId,
	output debugPkg::byteT interfaceId,
	output logic writeStrobe,
	output debugPkg::addrT writeAddress,
	output debugPkg::dataT writeData,
	output debugPkg::dataT modeOut,
	output logic readValid,
	output debugPkg::dataT readData32,
	output debugPkg::addrT readData64
);
	import debugPkg::*;

	stateT reqKind;
	stateT selRead;
	logic targetOk;
	wordT wLength;
	logic capture;
	logic loadCount;
	logic stepCount;
	logic lastWord;
	logic loadAddr;
	logic stepAddr;
	logic restoreAddr;
	addrT address;
	logic writeMode;
	logic logError;
	errT errCode;
	logic clearError;

	setupDecoder decoder (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.capture(capture),
		.setupWord(setupWord),
		.reqKind(reqKind),
		.targetOk(targetOk),
		.wLength(wLength),
		.targetGlobal(targetGlobal),
		.targetLocal(targetLocal),
		.targetSpecific(targetSpecific),
		.debugUnitId(debugUnitId),
		.interfaceId(interfaceId)
	);

	requestFsm #(.countWidth(countWidth)) fsm (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.reqKind(reqKind),
		.targetOk(targetOk),
		.lastWord(lastWord),
		.capture(capture),
		.loadCount(loadCount),
		.stepCount(stepCount),
		.loadAddr(loadAddr),
		.stepAddr(stepAddr),
		.restoreAddr(restoreAddr),
		.writeMode(writeMode),
		.selRead(selRead),
		.logError(logError),
		.errCode(errCode),
		.clearError(clearError),
		.busy(busy),
		.writeStrobe(writeStrobe),
		.readValid(readValid)
	);

	transferCounter #(.countWidth(countWidth)) counter (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.loadCount(loadCount),
		.stepCount(stepCount),
		.wLength(wLength),
		.lastWord(lastWord)
	);

	configAddress addrReg (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.loadAddr(loadAddr),
		.stepAddr(stepAddr),
		.restoreAddr(restoreAddr),
		.parameterBlock64(parameterBlock64),
		.address(address)
	);

	responseRegs response (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.writeMode(writeMode),
		.selRead(selRead),
		.logError(logError),
		.errCode(errCode),
		.clearError(clearError),
		.address(address),
		.parameterBlock32(parameterBlock32),
		.operatingModeIn(operatingModeIn),
		.modeOut(modeOut),
		.readData32(readData32),
		.readData64(readData64),
		.writeAddress(writeAddress),
		.writeData(writeData)
	);

endmodule

// ==== responseRegs.sv ====
module responseRegs (
	input logic clk,
	input logic rst,
	input logic enable,
	input logic writeMode,
	input debugPkg::stateT selRead,
	input logic logError,
	input debugPkg::errT errCode,
	input logic clearError,
	input debugPkg::addrT address,
	input debugPkg::dataT parameterBlock32,
	input debugPkg::dataT operatingModeIn,
	output debugPkg::dataT modeOut,
	output debugPkg::dataT readData32,
	output debugPkg::addrT readData64,
	output debugPkg::addrT writeAddress,
	output debugPkg::dataT writeData
);
	import debugPkg::*;

	errT errReg;   // last error seen

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			modeOut <= '0;
			errReg <= ErrNone;
		end
		else if (enable)
		begin
			if (writeMode)
				modeOut <= parameterBlock32;
			if (logError)
				errReg <= errCode;
			else if (clearError)
				errReg <= ErrNone;   // read once then cleared
		end
	end

	always_ff @(posedge clk)
	begin
		if (enable)
		begin
			case (selRead)
				GetAddress: readData64 <= address;
				GetMode: readData32 <= operatingModeIn;
				GetInfo: readData32 <= CapabilityWord;
				GetError: readData32 <= {24'h0, errReg};   // code before the clear
				SetData:
				begin
					writeAddress <= address;   // base + word index
					writeData <= parameterBlock32;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== configAddress.sv ====
module configAddress (
	input logic clk,
	input logic rst,
	input logic enable,
	input logic loadAddr,
	input logic stepAddr,
	input logic restoreAddr,
	input debugPkg::addrT parameterBlock64,
	output debugPkg::addrT address
);
	logic [63:0] base;   // address to return to after a burst

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			address <= '0;
			base <= '0;
		end
		else if (enable)
		begin
			if (loadAddr)
				address <= parameterBlock64;
			else if (restoreAddr)
				address <= base;   // last word of the burst
			else if (stepAddr)
				address <= address + 64'd1;

			// base frozen while a burst steps the address
			if (loadAddr)
				base <= parameterBlock64;
			else if (!stepAddr)
				base <= address;
		end
	end

endmodule

// ==== transferCounter.sv ====
module transferCounter #(
	parameter int countWidth = 16
) (
	input logic clk,
	input logic rst,
	input logic enable,
	input logic loadCount,
	input logic stepCount,
	input debugPkg::wordT wLength,
	output logic lastWord
);
	localparam logic [countWidth:0] countOne = 1;

	logic [countWidth:0] count;   // words still to go, one extra bit for wLength+1

	always_ff @(posedge clk)
	begin
		if (rst)
			count <= '0;
		else if (enable)
		begin
			if (loadCount)
				count <= {1'b0, wLength[countWidth-1:0]} + countOne;   // narrow width caps burst
			else if (stepCount)
				count <= count - countOne;
		end
	end

	assign lastWord = (count == countOne);

	noStepAtZero: assert property (@(posedge clk) disable iff (rst)
		(enable && stepCount) |-> (count != '0));

endmodule

// ==== requestFsm.sv ====
module requestFsm #(
	parameter int countWidth = 16
) (
	input logic clk,
	input logic rst,
	input logic enable,
	input debugPkg::stateT reqKind,
	input logic targetOk,
	input logic lastWord,
	output logic capture,
	output logic loadCount,
	output logic stepCount,
	output logic loadAddr,
	output logic stepAddr,
	output logic restoreAddr,
	output logic writeMode,
	output debugPkg::stateT selRead,
	output logic logError,
	output debugPkg::errT errCode,
	output logic clearError,
	output logic busy,
	output logic writeStrobe,
	output logic readValid
);
	import debugPkg::*;

	localparam int maxBurst = 2 ** countWidth;   // longest burst the counter can load

	stateT state;
	stateT nextState;
	logic badRequest;
	logic isGet;
	logic [countWidth:0] burstLen;   // enabled cycles spent in SetData so far

	assign badRequest = (reqKind == Idle);
	assign isGet = (state == GetAddress) || (state == GetMode)
		|| (state == GetInfo) || (state == GetError);

	always_comb
	begin
		nextState = Idle;
		case (state)
			Idle: nextState = Decode;   // setup word sampled on this edge
			Decode:
			begin
				if (badRequest || !targetOk)
					nextState = Idle;
				else
					nextState = reqKind;
			end
			SetData: nextState = lastWord ? Idle : SetData;
			default: nextState = Idle;   // single-cycle commands
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= Idle;
		else if (enable)
			state <= nextState;
	end

	assign capture = (state == Idle);
	assign loadCount = (state == Decode);
	assign stepCount = (state == SetData);
	assign loadAddr = (state == SetAddress);
	assign stepAddr = (state == SetData);
	assign restoreAddr = (state == SetData) && lastWord;   // back to base after last word
	assign writeMode = (state == SetMode);
	assign selRead = state;
	assign clearError = (state == GetError);

	// unknown request wins over a bad target
	assign logError = (state == Decode) && (badRequest || !targetOk);
	assign errCode = badRequest ? ErrInvalidRequest : ErrInvalidControl;

	assign busy = (state != Idle) && (state != Decode);

	// strobes line up with the registered write and read data
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			writeStrobe <= 1'b0;
			readValid <= 1'b0;
		end
		else
		begin
			writeStrobe <= enable && (state == SetData);
			readValid <= enable && isGet;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			burstLen <= '0;
		else if (enable)
			burstLen <= (state == SetData) ? burstLen + 1'b1 : '0;
	end

	// busy only ever starts out of Decode
	busyFromDecode: assert property (@(posedge clk) disable iff (rst)
		busy |-> (state != Idle) && ($past(busy) || $past(state) == Decode));

	// the counter must end every burst within its capacity
	burstBound: assert property (@(posedge clk) disable iff (rst)
		(state == SetData) |-> (burstLen < maxBurst));

endmodule

// ==== setupDecoder.sv ====
module setupDecoder (
	input logic clk,
	input logic rst,
	input logic enable,
	input logic capture,
	input debugPkg::setupT setupWord,
	output debugPkg::stateT reqKind,
	output logic targetOk,
	output debugPkg::wordT wLength,
	output logic targetGlobal,
	output logic targetLocal,
	output logic targetSpecific,
	output debugPkg::byteT debugUnitId,
	output debugPkg::byteT interfaceId
);
	import debugPkg::*;

	byteT reqType;
	byteT request;
	byteT classCode;   // wValue low byte
	byteT unitId;      // wIndex high byte
	logic unitZero;

	assign classCode = setupWord[39:32];
	assign unitId = setupWord[31:24];
	assign unitZero = (unitId == 8'h00);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			targetGlobal <= 1'b0;
			targetLocal <= 1'b0;
			targetSpecific <= 1'b0;
			debugUnitId <= '0;
			interfaceId <= '0;
		end
		else if (enable && capture)
		begin
			targetGlobal <= unitZero && (classCode == ClassGlobal);
			targetLocal <= unitZero && (classCode == ClassLocal);
			targetSpecific <= !unitZero && (classCode == ClassSpecific);
			debugUnitId <= unitId;
			interfaceId <= setupWord[23:16];
		end
	end

	always_ff @(posedge clk)
	begin
		if (enable && capture)
		begin
			reqType <= setupWord[63:56];
			request <= setupWord[55:48];
			wLength <= setupWord[15:0];   // burst is wLength+1 words
		end
	end

	// pick the command state, Idle marks an unknown request
	always_comb
	begin
		reqKind = Idle;
		if (reqType == ReqTypeSet)
		begin
			case (request)
				ReqSetConfigData: reqKind = SetData;
				ReqSetConfigAddress: reqKind = SetAddress;
				ReqSetOperatingMode: reqKind = SetMode;
				default: reqKind = Idle;
			endcase
		end
		else if (reqType == ReqTypeGet)
		begin
			case (request)
				ReqGetConfigAddress: reqKind = GetAddress;
				ReqGetOperatingMode: reqKind = GetMode;
				ReqGetInfo: reqKind = GetInfo;
				ReqGetError: reqKind = GetError;
				default: reqKind = Idle;
			endcase
		end
	end

	assign targetOk = targetGlobal || targetLocal || targetSpecific;

	oneTarget: assert property (@(posedge clk) disable iff (rst)
		$onehot0({targetGlobal, targetLocal, targetSpecific}));

endmodule

// ==== debugPkg.sv ====
package debugPkg;

	typedef logic [7:0] byteT;
	typedef logic [15:0] wordT;   // setup word fields
	typedef logic [31:0] dataT;
	typedef logic [63:0] addrT;   // config address space
	typedef logic [63:0] setupT;
	typedef logic [7:0] errT;

	// bmRequestType for class requests to the debug interface
	localparam byteT ReqTypeSet = 8'h21;   // host to device
	localparam byteT ReqTypeGet = 8'hA1;   // device to host

	localparam byteT ReqSetConfigData = 8'h01;
	localparam byteT ReqSetConfigAddress = 8'h03;
	localparam byteT ReqSetOperatingMode = 8'h05;
	localparam byteT ReqGetConfigAddress = 8'h83;
	localparam byteT ReqGetOperatingMode = 8'h85;
	localparam byteT ReqGetInfo = 8'h87;
	localparam byteT ReqGetError = 8'h88;

	// wValue low byte per target class, vendor codes are rejected
	localparam byteT ClassGlobal = 8'h00;     // with unit 0
	localparam byteT ClassLocal = 8'h02;      // with unit 0
	localparam byteT ClassSpecific = 8'h00;   // with unit nonzero

	localparam errT ErrNone = 8'h00;
	localparam errT ErrInvalidControl = 8'h08;
	localparam errT ErrInvalidRequest = 8'h09;

	typedef enum logic [3:0] {
		Idle,
		Decode,
		SetAddress,
		SetData,
		SetMode,
		GetAddress,
		GetMode,
		GetInfo,
		GetError
	} stateT;

	// bits 1,3,4,7,8: set config data, set/get config address, set/get operating mode
	localparam dataT CapabilityWord = 32'h0000_019A;

endpackage
